/* Bender.yml */
package:
  name: fetch_cluster

sources:
  - files:
      - gpu_fetch_pkg.sv
      - fetcher.sv
      - core_sequencer.sv
      - program_mem_arbiter.sv
      - fetch_cluster.sv
  - target: test
    files:
      - tb_fetch_cluster.sv

/* core_sequencer.sv */
// Per-core FETCH, DECODE, EXECUTE sequencer with PC update, jump and halt decode, retire record
`default_nettype none
`timescale 1ns/100ps

module core_sequencer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   start,
    input  logic [gpu_fetch_pkg::core_id_bits-1:0] core_id,
    input  gpu_fetch_pkg::fetcher_state_t          fetcher_state,
    input  logic [gpu_fetch_pkg::instr_bits-1:0]   instruction,
    output gpu_fetch_pkg::core_state_t             core_state,
    output logic [gpu_fetch_pkg::addr_bits-1:0]    pc,
    output gpu_fetch_pkg::retire_t                 retire
);
    import gpu_fetch_pkg::*;

    logic [3:0]           opcode;
    logic [addr_bits-1:0] immediate;
    logic                 is_jump;
    logic                 is_halt;
    logic [addr_bits-1:0] next_pc;

    // Instruction fields
    assign opcode    = instruction[instr_bits-1 -: 4];
    assign immediate = instruction[addr_bits-1:0];
    assign is_jump   = (opcode == op_jump);
    assign is_halt   = (opcode == op_halt);

    // Jump target or the following address, wrapping at the top
    assign next_pc = is_jump ? immediate : pc + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state <= CORE_IDLE;
            pc         <= '0;
        end else begin
            case (core_state)
                CORE_IDLE: begin
                    if (start) begin
                        core_state <= FETCH;
                        // Each core owns its own slice of program memory
                        pc         <= core_id * core_pc_stride;
                    end
                end
                FETCH: begin
                    // Wait here for as long as the memory takes
                    if (fetcher_state == FETCHED) begin
                        core_state <= DECODE;
                    end
                end
                DECODE: begin
                    core_state <= EXECUTE;
                end
                EXECUTE: begin
                    if (is_halt) begin
                        core_state <= HALTED;
                    end else begin
                        core_state <= FETCH;
                        pc         <= next_pc;
                    end
                end
                HALTED: begin
                    // Only reset leaves this state
                    core_state <= HALTED;
                end
                default: begin
                    core_state <= CORE_IDLE;
                end
            endcase
        end
    end

    // Retire record is valid for the single decode cycle
    always_comb begin
        retire.valid = (core_state == DECODE);
        retire.pc    = pc;
        retire.instr = instruction;
    end

endmodule

`default_nettype wire

/* fetch_cluster.sv */
// Top level with four sequencer and fetcher pairs sharing one program memory arbiter
`default_nettype none
`timescale 1ns/100ps

module fetch_cluster (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  start,
    output gpu_fetch_pkg::fetch_req_t                             mem_req,
    input  gpu_fetch_pkg::fetch_rsp_t                             mem_rsp,
    output gpu_fetch_pkg::retire_t [gpu_fetch_pkg::num_cores-1:0] retire,
    output logic                                                  done
);
    import gpu_fetch_pkg::*;

    core_state_t                         core_states    [num_cores];
    fetcher_state_t                      fetcher_states [num_cores];
    logic [addr_bits-1:0]                pcs            [num_cores];
    logic [instr_bits-1:0]               instructions   [num_cores];
    fetch_req_t [num_cores-1:0]          client_req;
    fetch_rsp_t [num_cores-1:0]          client_rsp;
    logic [num_cores-1:0]                core_halted;

    for (genvar g = 0; g < num_cores; g++) begin : gen_core
        core_sequencer core_sequencer_inst (
            .clk           (clk),
            .reset         (reset),
            .start         (start),
            .core_id       (core_id_bits'(g)),
            .fetcher_state (fetcher_states[g]),
            .instruction   (instructions[g]),
            .core_state    (core_states[g]),
            .pc            (pcs[g]),
            .retire        (retire[g])
        );

        fetcher fetcher_inst (
            .clk           (clk),
            .reset         (reset),
            .core_state    (core_states[g]),
            .current_pc    (pcs[g]),
            .mem_req       (client_req[g]),
            .mem_rsp       (client_rsp[g]),
            .fetcher_state (fetcher_states[g]),
            .instruction   (instructions[g])
        );

        assign core_halted[g] = (core_states[g] == HALTED);
    end

    program_mem_arbiter program_mem_arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .client_req (client_req),
        .client_rsp (client_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    // Run is over once every core has halted
    assign done = &core_halted;

endmodule

`default_nettype wire

/* fetch_stim.txt */
# M addr data = program memory word, E core pc instr = expected retire record (all hex)
# R min max = ack delay range in cycles (decimal)
R 3 9
# Core 0 steps, then jumps over two halts
M 00 2000
M 01 3001
M 02 1005
M 03 F003
M 04 F004
M 05 4005
M 06 F006
# Core 1 takes two jumps in a row
M 10 2110
M 11 1014
M 12 F112
M 13 F113
M 14 5114
M 15 1018
M 16 F116
M 17 F117
M 18 F118
# Core 2 runs straight through other opcodes
M 20 2220
M 21 0221
M 22 7222
M 23 E223
M 24 F224
# Core 3 starts with a jump
M 30 1034
M 31 F331
M 32 F332
M 33 F333
M 34 3334
M 35 1038
M 36 F336
M 37 F337
M 38 F338
# Expected traces
E 0 00 2000
E 0 01 3001
E 0 02 1005
E 0 05 4005
E 0 06 F006
E 1 10 2110
E 1 11 1014
E 1 14 5114
E 1 15 1018
E 1 18 F118
E 2 20 2220
E 2 21 0221
E 2 22 7222
E 2 23 E223
E 2 24 F224
E 3 30 1034
E 3 34 3334
E 3 35 1038
E 3 38 F338

/* fetcher.sv */
// Per-core instruction fetcher with a four-phase program memory read
`default_nettype none
`timescale 1ns/100ps

module fetcher (
    input  logic                                 clk,
    input  logic                                 reset,
    input  gpu_fetch_pkg::core_state_t           core_state,
    input  logic [gpu_fetch_pkg::addr_bits-1:0]  current_pc,
    output gpu_fetch_pkg::fetch_req_t            mem_req,
    input  gpu_fetch_pkg::fetch_rsp_t            mem_rsp,
    output gpu_fetch_pkg::fetcher_state_t        fetcher_state,
    output logic [gpu_fetch_pkg::instr_bits-1:0] instruction
);
    import gpu_fetch_pkg::*;

    logic rsp_taken;

    // Ack seen while waiting on the read
    assign rsp_taken = (fetcher_state == FETCHING) && mem_rsp.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetcher_state <= FETCHER_IDLE;
            mem_req       <= '0;
        end else begin
            case (fetcher_state)
                FETCHER_IDLE: begin
                    // Previous ack has to be gone before a new req
                    if (core_state == FETCH && !mem_rsp.ack) begin
                        fetcher_state <= FETCHING;
                        mem_req.req   <= 1'b1;
                        mem_req.addr  <= current_pc;
                    end
                end
                FETCHING: begin
                    if (rsp_taken) begin
                        fetcher_state <= FETCHED;
                        mem_req.req   <= 1'b0;
                    end
                end
                FETCHED: begin
                    // Hold the word until the core has moved on to decode
                    if (core_state == DECODE) begin
                        fetcher_state <= FETCHER_IDLE;
                    end
                end
                default: begin
                    fetcher_state <= FETCHER_IDLE;
                end
            endcase
        end
    end

    // Instruction word, kept until the next read completes
    always_ff @(posedge clk) begin
        if (rsp_taken) begin
            instruction <= mem_rsp.data;
        end
    end

endmodule

`default_nettype wire

/* gpu_fetch_pkg.sv */
// Fetch subsystem localparams, core and fetcher state enums, handshake and retire structs
`default_nettype none

package gpu_fetch_pkg;

    // Core count and widths
    localparam int num_cores    = 4;
    localparam int core_id_bits = 2;
    localparam int addr_bits    = 8;
    localparam int instr_bits   = 16;

    // Start address spacing between neighbouring cores
    localparam logic [addr_bits-1:0] core_pc_stride = 8'd16;

    // Opcodes live in the top nibble of the instruction
    localparam logic [3:0] op_jump = 4'h1;
    localparam logic [3:0] op_halt = 4'hF;

    // Core sequencer states
    typedef enum logic [2:0] {
        CORE_IDLE = 3'd0,
        FETCH     = 3'd1,
        DECODE    = 3'd2,
        EXECUTE   = 3'd3,
        HALTED    = 3'd4
    } core_state_t;

    // Fetcher states, a separate type from the core states
    typedef enum logic [1:0] {
        FETCHER_IDLE = 2'd0,
        FETCHING     = 2'd1,
        FETCHED      = 2'd2
    } fetcher_state_t;

    // Requester to responder half of the four-phase channel
    typedef struct packed {
        logic                 req;
        logic [addr_bits-1:0] addr;
    } fetch_req_t;

    // Responder to requester half
    typedef struct packed {
        logic                  ack;
        logic [instr_bits-1:0] data;
    } fetch_rsp_t;

    // One record per decoded instruction
    typedef struct packed {
        logic                  valid;
        logic [addr_bits-1:0]  pc;
        logic [instr_bits-1:0] instr;
    } retire_t;

endpackage

`default_nettype wire

/* program_mem_arbiter.sv */
// Round-robin arbiter of fetcher req/ack channels onto one program memory port
`default_nettype none
`timescale 1ns/100ps

module program_mem_arbiter (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  gpu_fetch_pkg::fetch_req_t [gpu_fetch_pkg::num_cores-1:0] client_req,
    output gpu_fetch_pkg::fetch_rsp_t [gpu_fetch_pkg::num_cores-1:0] client_rsp,
    output gpu_fetch_pkg::fetch_req_t                              mem_req,
    input  gpu_fetch_pkg::fetch_rsp_t                              mem_rsp
);
    import gpu_fetch_pkg::*;

    logic                    busy;
    logic [core_id_bits-1:0] grant;
    logic [core_id_bits-1:0] rr_ptr;
    logic                    port_idle;
    logic                    pick_valid;
    logic [core_id_bits-1:0] pick_idx;
    logic [core_id_bits-1:0] cand;

    // Both halves of the handshake are back to zero
    assign port_idle = !mem_req.req && !mem_rsp.ack;

    // First requester at or after the pointer
    // Walk the offsets downward so the nearest one is kept last
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = rr_ptr;
        cand       = rr_ptr;
        for (int k = num_cores - 1; k >= 0; k--) begin
            cand = rr_ptr + core_id_bits'(k);
            if (client_req[cand].req) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            grant   <= '0;
            rr_ptr  <= '0;
            mem_req <= '0;
        end else if (!busy) begin
            if (port_idle && pick_valid) begin
                busy    <= 1'b1;
                grant   <= pick_idx;
                mem_req <= client_req[pick_idx];
            end
        end else begin
            if (port_idle) begin
                // Full four-phase cycle done, move past the winner
                busy   <= 1'b0;
                rr_ptr <= grant + 1'b1;
            end else begin
                // Follow the winner, req falls one cycle after the fetcher drops it
                mem_req <= client_req[grant];
            end
        end
    end

    // Ack and data reach the granted fetcher only
    always_comb begin
        for (int i = 0; i < num_cores; i++) begin
            client_rsp[i] = '0;
            if (busy && grant == core_id_bits'(i)) begin
                client_rsp[i] = mem_rsp;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_fetch_cluster.sv */
// Testbench for fetch_cluster with stim file loader, memory responder, trace and port checks
`default_nettype none
`timescale 1ns/100ps

module tb_fetch_cluster;
    import gpu_fetch_pkg::*;

    localparam int max_entries = 64;
    localparam int num_tests   = 6;

    logic                    clk;
    logic                    reset;
    logic                    start;
    fetch_req_t              mem_req;
    fetch_rsp_t              mem_rsp;
    retire_t [num_cores-1:0] retire;
    logic                    done;

    logic [instr_bits-1:0] mem       [256];
    logic [addr_bits-1:0]  exp_pc    [num_cores][max_entries];
    logic [instr_bits-1:0] exp_instr [num_cores][max_entries];
    int                    exp_count [num_cores];
    int                    exp_head  [num_cores];
    logic                  halt_seen [num_cores];
    logic                  last_jump [num_cores];
    logic [addr_bits-1:0]  last_target [num_cores];
    int                    first_owner [num_cores];
    int                    grants_seen;
    int                    errors [num_tests];
    int                    checks [num_tests];
    string                 test_names [num_tests];
    int                    delay_min;
    int                    delay_max;
    int                    total_expected;
    int                    cycle_limit;
    int                    cycles;
    logic                  running;
    logic                  finished;
    logic                  prev_req;
    logic                  prev_ack;
    logic [addr_bits-1:0]  prev_addr;

    fetch_cluster fetch_cluster_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .retire  (retire),
        .done    (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int entries_left(input int c);
        return exp_count[c] - exp_head[c];
    endfunction

    function automatic logic queues_empty();
        logic empty;
        empty = 1'b1;
        for (int c = 0; c < num_cores; c++) begin
            if (entries_left(c) != 0) begin
                empty = 1'b0;
            end
        end
        return empty;
    endfunction

    function automatic int pick_delay();
        return delay_min + int'($urandom % (delay_max - delay_min + 1));
    endfunction

    task automatic init_state();
        test_names = '{"reset_state", "retire_trace", "jump_target", "port_protocol",
                       "halt_done", "contention"};
        for (int t = 0; t < num_tests; t++) begin
            errors[t] = 0;
            checks[t] = 0;
        end
        for (int c = 0; c < num_cores; c++) begin
            exp_count[c]   = 0;
            exp_head[c]    = 0;
            halt_seen[c]   = 1'b0;
            last_jump[c]   = 1'b0;
            last_target[c] = '0;
            first_owner[c] = 0;
        end
        // Unlisted words are halts tagged with their own address
        for (int a = 0; a < 256; a++) begin
            mem[a] = 16'hF000 | 16'(a);
        end
        delay_min      = 0;
        delay_max      = 0;
        total_expected = 0;
        grants_seen    = 0;
        cycles         = 0;
        running        = 1'b0;
        finished       = 1'b0;
        prev_req       = 1'b0;
        prev_ack       = 1'b0;
        prev_addr      = '0;
    endtask

    task automatic load_stim(output logic ok);
        int               fd;
        int               code;
        logic [7:0]       tag;
        int               a;
        int               b;
        int               c;
        logic [8*128-1:0] rest;
        fd = $fopen("fetch_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", tag);
                if (code == 1) begin
                    if (tag == "M") begin
                        code = $fscanf(fd, "%h %h", a, b);
                        mem[a[7:0]] = b[15:0];
                    end else if (tag == "E") begin
                        code = $fscanf(fd, "%h %h %h", c, a, b);
                        if (c < num_cores && exp_count[c] < max_entries) begin
                            exp_pc[c][exp_count[c]]    = a[7:0];
                            exp_instr[c][exp_count[c]] = b[15:0];
                            exp_count[c]++;
                            total_expected++;
                        end
                    end else if (tag == "R") begin
                        code = $fscanf(fd, "%d %d", delay_min, delay_max);
                    end else begin
                        // Comment line, skip the rest of it
                        code = $fgets(rest, fd);
                    end
                end
            end
            $fclose(fd);
        end
        ok = (fd != 0) && (total_expected > 0) && (delay_max >= delay_min);
    endtask

    task automatic check_reset_state();
        logic any_valid;
        any_valid = 1'b0;
        for (int c = 0; c < num_cores; c++) begin
            any_valid = any_valid | (retire[c].valid !== 1'b0);
        end
        checks[0]++;
        assert (mem_req.req === 1'b0 && !any_valid && done === 1'b0) else begin
            $display("At %0t the memory req, a retire valid or done is not low around reset",
                     $time);
            errors[0]++;
        end
    endtask

    task automatic check_port();
        int owner;
        checks[3]++;
        assert (!(mem_req.req && !prev_req && prev_ack)) else begin
            $display("At %0t the memory req rose while ack was still high", $time);
            errors[3]++;
        end
        if (mem_req.req && prev_req) begin
            assert (mem_req.addr == prev_addr) else begin
                $display("[ERROR] mem_req.addr changed under req, expected %h actual %h",
                         prev_addr, mem_req.addr);
                errors[3]++;
            end
        end
        if (mem_req.req && !prev_req) begin
            owner = int'(mem_req.addr) / int'(core_pc_stride);
            assert (owner < num_cores && entries_left(owner % num_cores) > 0) else begin
                $display("Fetch from address %h that no unfinished core expects", mem_req.addr);
                errors[3]++;
            end
            // First requests after start show the order of service under contention
            if (grants_seen < num_cores) begin
                first_owner[grants_seen] = owner;
                grants_seen++;
            end
        end
        prev_req  = mem_req.req;
        prev_ack  = mem_rsp.ack;
        prev_addr = mem_req.addr;
    endtask

    task automatic check_retire(input int c);
        int idx;
        idx = exp_head[c];
        checks[4]++;
        assert (!halt_seen[c]) else begin
            $display("Core %0d retired pc %h after it had halted", c, retire[c].pc);
            errors[4]++;
        end
        assert (idx < exp_count[c]) else begin
            $display("Core %0d retired pc %h with no expected entries left", c, retire[c].pc);
            errors[1]++;
        end
        if (idx < exp_count[c]) begin
            checks[1] += 2;
            assert (retire[c].pc == exp_pc[c][idx]) else begin
                $display("[ERROR] retire[%0d].pc expected %h actual %h",
                         c, exp_pc[c][idx], retire[c].pc);
                errors[1]++;
            end
            assert (retire[c].instr == exp_instr[c][idx]) else begin
                $display("[ERROR] retire[%0d].instr expected %h actual %h",
                         c, exp_instr[c][idx], retire[c].instr);
                errors[1]++;
            end
            exp_head[c]++;
        end
        // The record after a jump has to sit at the immediate
        if (last_jump[c]) begin
            checks[2]++;
            assert (retire[c].pc == last_target[c]) else begin
                $display("[ERROR] retire[%0d].pc after jump expected %h actual %h",
                         c, last_target[c], retire[c].pc);
                errors[2]++;
            end
        end
        last_jump[c]   = (retire[c].instr[15:12] == op_jump);
        last_target[c] = retire[c].instr[addr_bits-1:0];
        if (retire[c].instr[15:12] == op_halt) begin
            halt_seen[c] = 1'b1;
        end
    endtask

    // Sampled on the rising edge, inputs only move on the falling edge
    always @(posedge clk) begin
        if (running) begin
            cycles++;
            check_port();
            for (int c = 0; c < num_cores; c++) begin
                if (retire[c].valid === 1'b1) begin
                    check_retire(c);
                end
            end
            if (done === 1'b1) begin
                checks[4]++;
                assert (queues_empty()) else begin
                    $display("done is high while expected entries remain");
                    errors[4]++;
                end
            end
        end
    end

    // Program memory on the far side of the four-phase handshake
    initial begin : responder
        int wait_cycles;
        int seed_val;
        mem_rsp  = '0;
        seed_val = $urandom(43);
        forever begin
            @(negedge clk);
            if (mem_req.req === 1'b1 && !mem_rsp.ack) begin
                wait_cycles = pick_delay();
                repeat (wait_cycles) @(negedge clk);
                mem_rsp.data = mem[mem_req.addr];
                mem_rsp.ack  = 1'b1;
                while (mem_req.req === 1'b1) @(negedge clk);
                wait_cycles = pick_delay();
                repeat (wait_cycles) @(negedge clk);
                mem_rsp = '0;
            end
        end
    end

    initial begin : watchdog
        int waited;
        waited = 0;
        wait (running === 1'b1);
        while (!finished && waited < cycle_limit) begin
            @(posedge clk);
            waited++;
        end
        if (!finished) begin
            $display("Timeout after %0d cycles before all traces completed", waited);
            for (int c = 0; c < num_cores; c++) begin
                if (entries_left(c) > 0) begin
                    $display("Core %0d still had %0d expected entries", c, entries_left(c));
                end
            end
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic run_tests();
        repeat (2) begin
            @(negedge clk);
            check_reset_state();
        end
        reset = 1'b0;
        @(negedge clk);
        check_reset_state();
        $display("%s: %0d checks, %0d errors", test_names[0], checks[0], errors[0]);
        cycle_limit = total_expected * (2 * delay_max + 8) * num_cores + 100;
        running = 1'b1;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (done !== 1'b1) @(posedge clk);
        // Let stray records after the halts show up
        repeat (8) @(negedge clk);
        finished = 1'b1;
        running  = 1'b0;
        for (int c = 0; c < num_cores; c++) begin
            checks[4]++;
            assert (halt_seen[c] && entries_left(c) == 0) else begin
                $display("Core %0d did not finish its trace with a halt", c);
                errors[4]++;
            end
        end
        for (int t = 1; t < num_tests - 1; t++) begin
            $display("%s: %0d checks, %0d errors", test_names[t], checks[t], errors[t]);
        end
        // All cores ask at once, so round-robin serves them from core 0 upward
        for (int c = 0; c < num_cores; c++) begin
            checks[5]++;
            assert (c < grants_seen && first_owner[c] == c) else begin
                $display("[ERROR] owner of mem_req.addr in request %0d expected %h actual %h",
                         c, c, first_owner[c]);
                errors[5]++;
            end
        end
        $display("%s: all traces done after %0d of %0d allowed cycles, %0d errors",
                 test_names[5], cycles, cycle_limit, errors[5]);
    endtask

    task automatic report();
        int total_err;
        int total_chk;
        int failed;
        total_err = 0;
        total_chk = 0;
        failed    = 0;
        for (int t = 0; t < num_tests; t++) begin
            total_err += errors[t];
            total_chk += checks[t];
            if (errors[t] != 0) begin
                failed++;
            end
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 num_tests, failed, total_chk, total_err);
        if (total_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    initial begin : main
        logic stim_ok;
        reset = 1'b1;
        start = 1'b0;
        init_state();
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("Stim file fetch_stim.txt missing or incomplete");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            run_tests();
            report();
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
gpu_fetch_pkg.sv
fetcher.sv
core_sequencer.sv
program_mem_arbiter.sv
fetch_cluster.sv
tb_fetch_cluster.sv
